//--- Makefile
# Verilator build and run of the bus monitor testbench
# all variables can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bus_monitor
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

# line the testbench prints on success
PASS_MSG  := TEST RESULT: PASS

SIM_EXE   := $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(SIM_EXE) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- capture/bus_capture.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module bus_capture
  import bus_mon_pkg::*;
(
  input  logic      bus,
  input  logic      reset,
  input  bus_req_t  bus_req,
  input  bus_rsp_t  bus_rsp,
  input  mon_cfg_t  cfg,
  output xfer_rec_t xfer,
  output logic      xfer_vld
);

  // saturation value of the wait counter
  localparam logic [`BUS_MON_WAIT_W-1:0] WAIT_MAX = {`BUS_MON_WAIT_W{1'b1}};

  //////////////////////////////////////////////////////////////////////
  // handshake and wait cycles
  //////////////////////////////////////////////////////////////////////

  logic                       hsk;
  logic                       stall;
  logic                       in_window;
  logic [`BUS_MON_WAIT_W-1:0] wait_cnt;

  // transfer happens when both sides agree
  assign hsk   = bus_req.vld & bus_rsp.rdy;
  // request pending but slave not ready
  assign stall = bus_req.vld & ~bus_rsp.rdy;

  // window check on the live address
  assign in_window = cfg.enable &
                     ((bus_req.adr & cfg.mask) == (cfg.base & cfg.mask));

  // stalls since previous handshake, sticks at max
  always_ff @(posedge bus) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (hsk) begin
      wait_cnt <= '0;
    end else if (stall && (wait_cnt != WAIT_MAX)) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 1, registered request
  //////////////////////////////////////////////////////////////////////

  logic      s1_vld;
  xfer_rec_t s1_rec;

  always_ff @(posedge bus) begin
    if (reset) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= hsk & in_window;
    end
  end

  // payload, no reset needed
  always_ff @(posedge bus) begin
    if (hsk) begin
      s1_rec.dir      <= xfer_dir_e'(bus_req.wen);
      s1_rec.ben      <= bus_req.ben;
      s1_rec.wait_cnt <= wait_cnt;
      s1_rec.adr      <= bus_req.adr;
      // write data for now, replaced by rdt on reads
      s1_rec.dat      <= bus_req.wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, pair read data and emit
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset) begin
      xfer_vld <= 1'b0;
    end else begin
      xfer_vld <= s1_vld;
    end
  end

  always_ff @(posedge bus) begin
    if (s1_vld) begin
      xfer <= s1_rec;
      // rdt returns the cycle after the handshake
      if (s1_rec.dir == DIR_READ) begin
        xfer.dat <= bus_rsp.rdt;
      end
    end
  end

endmodule

//--- common/bus_mon_cfg.svh
`ifndef BUS_MON_CFG_SVH
`define BUS_MON_CFG_SVH

//////////////////////////////////////////////////////////////////////
// system bus geometry
//////////////////////////////////////////////////////////////////////

// address width
`define BUS_MON_AW 32

// data width
`define BUS_MON_DW 32

// byte enable width, one bit per data byte
`define BUS_MON_BW (`BUS_MON_DW/8)

//////////////////////////////////////////////////////////////////////
// monitor sizing
//////////////////////////////////////////////////////////////////////

// trace entries, power of two
`define BUS_MON_TRACE_DEPTH 16

// per-transfer wait counter, saturating
`define BUS_MON_WAIT_W 8

`endif

//--- common/bus_mon_pkg.sv
`include "bus_mon_cfg.svh"

package bus_mon_pkg;

  //////////////////////////////////////////////////////////////////////
  // observed system bus
  //////////////////////////////////////////////////////////////////////

  // request side as seen on the bus
  typedef struct packed {
    logic                   vld;
    logic                   wen;
    logic [`BUS_MON_BW-1:0] ben;
    logic [`BUS_MON_AW-1:0] adr;
    logic [`BUS_MON_DW-1:0] wdt;
  } bus_req_t;

  // response side, rdt one cycle after handshake
  typedef struct packed {
    logic                   rdy;
    logic [`BUS_MON_DW-1:0] rdt;
  } bus_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // monitor records and config
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    DIR_READ  = 1'b0,
    DIR_WRITE = 1'b1
  } xfer_dir_e;

  // one captured transfer
  typedef struct packed {
    xfer_dir_e                  dir;
    logic [`BUS_MON_BW-1:0]     ben;
    logic [`BUS_MON_WAIT_W-1:0] wait_cnt;
    logic [`BUS_MON_AW-1:0]     adr;
    logic [`BUS_MON_DW-1:0]     dat;
  } xfer_rec_t;

  // address window, match when (adr & mask) == (base & mask)
  typedef struct packed {
    logic                   enable;
    logic [`BUS_MON_AW-1:0] base;
    logic [`BUS_MON_AW-1:0] mask;
  } mon_cfg_t;

  // wrapping statistics counters
  typedef struct packed {
    logic [31:0] reads;
    logic [31:0] writes;
    logic [31:0] waits;
  } stats_t;

  //////////////////////////////////////////////////////////////////////
  // APB host port
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register map, byte offsets
  typedef enum logic [7:0] {
    REG_CTRL       = 8'h00,
    REG_BASE       = 8'h04,
    REG_MASK       = 8'h08,
    REG_READS      = 8'h0C,
    REG_WRITES     = 8'h10,
    REG_WAITS      = 8'h14,
    REG_STATUS     = 8'h18,
    REG_TRACE_ADR  = 8'h1C,
    REG_TRACE_DAT  = 8'h20,
    REG_TRACE_INFO = 8'h24
  } reg_addr_e;

endpackage

//--- filelist.f
+incdir+common
common/bus_mon_pkg.sv
capture/bus_capture.sv
src/bus_stats.sv
trace/trace_fifo.sv
src/apb_regs.sv
src/bus_monitor_top.sv
testbench/tb_bus_monitor.sv

//--- src/apb_regs.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module apb_regs
  import bus_mon_pkg::*;
(
  input  logic                                   bus,
  input  logic                                   reset,
  input  apb_req_t                               apb_req,
  output apb_rsp_t                               apb_rsp,
  output mon_cfg_t                               cfg,
  output logic                                   clear,
  input  stats_t                                 stats,
  input  xfer_rec_t                              head,
  input  logic [$clog2(`BUS_MON_TRACE_DEPTH):0]  level,
  input  logic [15:0]                            drops,
  output logic                                   pop
);

  //////////////////////////////////////////////////////////////////////
  // access phase decode
  //////////////////////////////////////////////////////////////////////

  logic      access;
  logic      wr_acc;
  logic      rd_acc;
  logic      fifo_empty;
  logic      unmapped;
  reg_addr_e addr;

  // second cycle of a transfer, never stretched
  assign access = apb_req.psel & apb_req.penable;
  assign wr_acc = access & apb_req.pwrite;
  assign rd_acc = access & ~apb_req.pwrite;

  assign addr       = reg_addr_e'(apb_req.paddr);
  assign fifo_empty = (level == '0);

  //////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////

  logic [31:0] rdata;

  always_comb begin
    rdata    = '0;
    unmapped = 1'b0;
    case (addr)
      REG_CTRL:       rdata = {31'd0, cfg.enable};
      REG_BASE:       rdata = cfg.base;
      REG_MASK:       rdata = cfg.mask;
      REG_READS:      rdata = stats.reads;
      REG_WRITES:     rdata = stats.writes;
      REG_WAITS:      rdata = stats.waits;
      // drops high half, level low byte
      REG_STATUS: begin
        rdata        = 32'(level);
        rdata[31:16] = drops;
      end
      REG_TRACE_ADR:  rdata = head.adr;
      REG_TRACE_DAT:  rdata = head.dat;
      // dir bit 0, ben 7:4, wait 15:8
      REG_TRACE_INFO: rdata = {16'd0, head.wait_cnt, head.ben, 3'd0, head.dir};
      default:        unmapped = 1'b1;
    endcase
  end

  // response fields valid during the access phase only
  assign apb_rsp.prdata  = rd_acc ? rdata : '0;
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access &
                           (unmapped | (rd_acc & (addr == REG_TRACE_INFO) & fifo_empty));

  //////////////////////////////////////////////////////////////////////
  // side effects
  //////////////////////////////////////////////////////////////////////

  // info read consumes the head entry
  assign pop = rd_acc & (addr == REG_TRACE_INFO) & ~fifo_empty;

  // bit 1 of a CTRL write, one cycle
  assign clear = wr_acc & (addr == REG_CTRL) & apb_req.pwdata[1];

  // config registers, latched at end of access phase
  // read-only offsets fall through silently
  always_ff @(posedge bus) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr_acc) begin
      case (addr)
        REG_CTRL: cfg.enable <= apb_req.pwdata[0];
        REG_BASE: cfg.base   <= apb_req.pwdata;
        REG_MASK: cfg.mask   <= apb_req.pwdata;
        default:  ;
      endcase
    end
  end

endmodule

//--- src/bus_monitor_top.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module bus_monitor_top
  import bus_mon_pkg::*;
(
  input  logic     bus,
  input  logic     reset,
  input  bus_req_t bus_req,
  input  bus_rsp_t bus_rsp,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  localparam int LW = $clog2(`BUS_MON_TRACE_DEPTH) + 1;

  //////////////////////////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////////////////////////

  // capture to stats and trace
  xfer_rec_t   xfer;
  logic        xfer_vld;

  // trace to registers
  xfer_rec_t   head;
  logic [LW-1:0] level;
  logic [15:0] drops;
  logic        pop;

  // registers to capture and stats
  mon_cfg_t    cfg;
  logic        clear;
  stats_t      stats;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  // input side
  bus_capture u_capture (
    .bus      (bus),
    .reset    (reset),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .cfg      (cfg),
    .xfer     (xfer),
    .xfer_vld (xfer_vld)
  );

  bus_stats u_stats (
    .bus      (bus),
    .reset    (reset),
    .xfer     (xfer),
    .xfer_vld (xfer_vld),
    .clear    (clear),
    .stats    (stats)
  );

  trace_fifo #(
    .DEPTH (`BUS_MON_TRACE_DEPTH)
  ) u_trace (
    .bus      (bus),
    .reset    (reset),
    .push_rec (xfer),
    .push     (xfer_vld),
    .pop      (pop),
    .head     (head),
    .level    (level),
    .drops    (drops)
  );

  // host side
  apb_regs u_regs (
    .bus      (bus),
    .reset    (reset),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .cfg      (cfg),
    .clear    (clear),
    .stats    (stats),
    .head     (head),
    .level    (level),
    .drops    (drops),
    .pop      (pop)
  );

endmodule

//--- src/bus_stats.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module bus_stats
  import bus_mon_pkg::*;
(
  input  logic      bus,
  input  logic      reset,
  input  xfer_rec_t xfer,
  input  logic      xfer_vld,
  input  logic      clear,
  output stats_t    stats
);

  //////////////////////////////////////////////////////////////////////
  // per-record increments
  //////////////////////////////////////////////////////////////////////

  logic        is_read;
  logic        is_write;
  logic [31:0] wait_add;

  // direction split of the incoming record
  assign is_read  = xfer_vld & (xfer.dir == DIR_READ);
  assign is_write = xfer_vld & (xfer.dir == DIR_WRITE);

  // zero extended wait count, nothing added without a record
  assign wait_add = xfer_vld ? 32'(xfer.wait_cnt) : 32'd0;

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  // read count, wraps at 32 bits
  always_ff @(posedge bus) begin
    if (reset || clear) begin
      stats.reads <= '0;
    end else if (is_read) begin
      stats.reads <= stats.reads + 1'b1;
    end
  end

  // write count
  always_ff @(posedge bus) begin
    if (reset || clear) begin
      stats.writes <= '0;
    end else if (is_write) begin
      stats.writes <= stats.writes + 1'b1;
    end
  end

  // total wait cycles over all recorded transfers
  // clear wins over a same cycle update
  always_ff @(posedge bus) begin
    if (reset || clear) begin
      stats.waits <= '0;
    end else if (xfer_vld) begin
      stats.waits <= stats.waits + wait_add;
    end
  end

endmodule

//--- testbench/tb_bus_monitor.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module tb_bus_monitor
  import bus_mon_pkg::*;
();

  localparam logic [31:0] SEED = 32'h159135ac;
  // several times the cycles the directed tests need
  localparam int MAX_CYCLES = 4000;
  // records reach FIFO and counters 3 cycles after the handshake
  localparam int PIPE_CYCLES = 3;

  logic     bus;
  logic     reset;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  // reference model state
  xfer_rec_t   exp_q[$];
  stats_t      exp_stats;
  int          exp_drops;
  logic        m_enable;
  logic [31:0] m_base;
  logic [31:0] m_mask;

  bus_monitor_top DUT (
    .bus     (bus),
    .reset   (reset),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  // run limit
  always @(posedge bus) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: simulation still running after %0d clock cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_rec(input xfer_rec_t got, input xfer_rec_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t: %s got dir %0d ben %h wait %0d adr %08h dat %08h",
               $time, what, got.dir, got.ben, got.wait_cnt, got.adr, got.dat);
      $display("       expected dir %0d ben %h wait %0d adr %08h dat %08h",
               exp.dir, exp.ben, exp.wait_cnt, exp.adr, exp.dat);
    end
  endtask

  task automatic check_stats(input stats_t got, input stats_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t: %s got reads %0d writes %0d waits %0d", $time, what,
               got.reads, got.writes, got.waits);
      $display("       expected reads %0d writes %0d waits %0d",
               exp.reads, exp.writes, exp.waits);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // masked address compare
  function automatic logic window_hit(input logic [31:0] adr);
    return m_enable && ((adr & m_mask) == (m_base & m_mask));
  endfunction

  task automatic model_record(input xfer_rec_t rec);
    if (window_hit(rec.adr)) begin
      if (rec.dir == DIR_READ) begin
        exp_stats.reads = exp_stats.reads + 32'd1;
      end else begin
        exp_stats.writes = exp_stats.writes + 32'd1;
      end
      exp_stats.waits = exp_stats.waits + 32'(rec.wait_cnt);
      // full trace loses the record
      if (exp_q.size() < `BUS_MON_TRACE_DEPTH) begin
        exp_q.push_back(rec);
      end else if (exp_drops < 65535) begin
        exp_drops++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge bus);
      #2;
    end
  endtask

  // one transfer stalled for waits cycles before the handshake
  task automatic bus_xfer(input logic wen, input logic [31:0] adr, input int waits);
    xfer_rec_t rec;
    rec.dir      = wen ? DIR_WRITE : DIR_READ;
    rec.ben      = 4'($urandom_range(15, 1));
    rec.adr      = adr;
    rec.dat      = $urandom;
    rec.wait_cnt = (waits > 255) ? 8'hFF : 8'(waits);
    bus_req.vld  = 1'b1;
    bus_req.wen  = wen;
    bus_req.ben  = rec.ben;
    bus_req.adr  = adr;
    bus_req.wdt  = rec.dat;
    bus_rsp.rdy  = 1'b0;
    idle(waits);
    bus_rsp.rdy  = 1'b1;
    @(posedge bus);
    #2;
    bus_req.vld  = 1'b0;
    bus_rsp.rdy  = 1'b0;
    // read data one cycle after the handshake
    if (!wen) begin
      bus_rsp.rdt = $urandom;
      rec.dat     = bus_rsp.rdt;
    end
    model_record(rec);
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB side
  //////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge bus);
    #2;
    apb_req.penable = 1'b1;
    // sample mid access phase where comb outputs have settled
    #10;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
      errors++;
      $display("APB slave did not raise pready in the access phase at offset %02h", addr);
    end
    @(posedge bus);
    #2;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  // register read that must not fail
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_word({31'd0, err}, 32'd0, $sformatf("pslverr on read of %02h", addr));
  endtask

  task automatic set_ctrl(input logic en, input logic clr);
    logic err;
    apb_write(REG_CTRL, {30'd0, clr, en}, err);
    check_word({31'd0, err}, 32'd0, "pslverr on CTRL write");
    m_enable = en;
    if (clr) exp_stats = '0;
  endtask

  task automatic set_window(input logic [31:0] base, input logic [31:0] mask);
    logic err;
    apb_write(REG_BASE, base, err);
    check_word({31'd0, err}, 32'd0, "pslverr on BASE write");
    apb_write(REG_MASK, mask, err);
    check_word({31'd0, err}, 32'd0, "pslverr on MASK write");
    m_base = base;
    m_mask = mask;
  endtask

  task automatic read_stats(output stats_t s);
    read_reg(REG_READS, s.reads);
    read_reg(REG_WRITES, s.writes);
    read_reg(REG_WAITS, s.waits);
  endtask

  // level in the low byte and drops in the high half
  task automatic check_status(input string what);
    logic [31:0] st;
    read_reg(REG_STATUS, st);
    check_word(st, {16'(exp_drops), 16'(exp_q.size())}, what);
  endtask

  // read the head entry and pop it with the INFO read
  task automatic read_trace(output xfer_rec_t rec, output logic err);
    logic [31:0] w;
    logic        e_adr;
    logic        e_dat;
    apb_read(REG_TRACE_ADR, w, e_adr);
    rec.adr = w;
    apb_read(REG_TRACE_DAT, w, e_dat);
    rec.dat = w;
    apb_read(REG_TRACE_INFO, w, err);
    rec.dir      = xfer_dir_e'(w[0]);
    rec.ben      = w[7:4];
    rec.wait_cnt = w[15:8];
    err = err | e_adr | e_dat;
  endtask

  task automatic drain_trace(input string what);
    xfer_rec_t got;
    xfer_rec_t exp;
    logic      err;
    while (exp_q.size() > 0) begin
      read_trace(got, err);
      exp = exp_q.pop_front();
      check_word({31'd0, err}, 32'd0, {what, " pslverr on trace read"});
      check_rec(got, exp, what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_disable();
    logic [31:0] w;
    stats_t      s;
    read_reg(REG_CTRL, w);
    check_word(w, 32'd0, "CTRL after reset");
    read_reg(REG_BASE, w);
    check_word(w, 32'd0, "BASE after reset");
    read_reg(REG_MASK, w);
    check_word(w, 32'd0, "MASK after reset");
    read_stats(s);
    check_stats(s, '0, "stats after reset");
    check_status("status after reset");
    // monitor off so nothing is recorded
    bus_xfer(1'b1, $urandom, 0);
    bus_xfer(1'b0, $urandom, 2);
    bus_xfer(1'b1, $urandom, 0);
    idle(PIPE_CYCLES);
    read_stats(s);
    check_stats(s, exp_stats, "stats while disabled");
    check_status("status while disabled");
  endtask

  task automatic test_capture();
    set_window(32'd0, 32'd0);
    set_ctrl(1'b1, 1'b0);
    for (int i = 0; i < 8; i++) begin
      if (i == 5) idle(2);
      bus_xfer(i % 3 != 1, $urandom, (i % 4 == 2) ? i : 0);
    end
    idle(PIPE_CYCLES);
    check_status("status after capture");
    drain_trace("capture trace");
    check_status("status after capture drain");
  endtask

  task automatic test_window();
    logic [31:0] w;
    stats_t      s;
    set_ctrl(1'b1, 1'b1);
    set_window(32'h4000_0000, 32'hF000_0000);
    // config registers read back what was written
    read_reg(REG_CTRL, w);
    check_word(w, {31'd0, m_enable}, "CTRL readback");
    read_reg(REG_BASE, w);
    check_word(w, m_base, "BASE readback");
    read_reg(REG_MASK, w);
    check_word(w, m_mask, "MASK readback");
    // top nibble cycles through 3 to 5 and only nibble 4 hits
    for (int i = 0; i < 10; i++) begin
      bus_xfer(i[0], {4'(i % 3 + 3), 28'($urandom)}, i % 3);
    end
    idle(PIPE_CYCLES);
    read_stats(s);
    check_stats(s, exp_stats, "stats with window");
    check_status("status with window");
    drain_trace("window trace");
  endtask

  task automatic test_stats_clear();
    stats_t s;
    set_window(32'd0, 32'd0);
    set_ctrl(1'b1, 1'b1);
    bus_xfer(1'b1, $urandom, 3);
    bus_xfer(1'b1, $urandom, 0);
    bus_xfer(1'b0, $urandom, 7);
    bus_xfer(1'b0, $urandom, 1);
    // long stall saturates wait_cnt at 255
    bus_xfer(1'b0, $urandom, 300);
    idle(PIPE_CYCLES);
    read_stats(s);
    check_stats(s, exp_stats, "stats with long stall");
    drain_trace("stall trace");
    set_ctrl(1'b1, 1'b1);
    read_stats(s);
    check_stats(s, exp_stats, "stats after clear");
  endtask

  task automatic test_overflow();
    for (int i = 0; i < 20; i++) begin
      bus_xfer(1'b1, $urandom, 0);
    end
    idle(PIPE_CYCLES);
    check_status("status after overflow");
    // first 16 kept and the rest dropped
    drain_trace("overflow trace");
    check_status("status after overflow drain");
  endtask

  task automatic test_apb_errors();
    logic [31:0] w;
    logic        err;
    xfer_rec_t   got;
    xfer_rec_t   exp;
    apb_read(8'h28, w, err);
    check_word({31'd0, err}, 32'd1, "pslverr on unmapped offset");
    apb_read(REG_TRACE_INFO, w, err);
    check_word({31'd0, err}, 32'd1, "pslverr on empty trace pop");
    // write to a read-only register is ignored
    apb_write(REG_READS, 32'h1234_5678, err);
    check_word({31'd0, err}, 32'd0, "pslverr on read-only write");
    read_reg(REG_READS, w);
    check_word(w, exp_stats.reads, "READS after ignored write");
    bus_xfer(1'b0, $urandom, 1);
    bus_xfer(1'b1, $urandom, 0);
    idle(PIPE_CYCLES);
    check_status("status before pop");
    read_trace(got, err);
    exp = exp_q.pop_front();
    check_word({31'd0, err}, 32'd0, "pslverr on trace pop with entries");
    check_rec(got, exp, "popped entry");
    check_status("status after one pop");
    drain_trace("error test trace");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    reset     = 1'b1;
    bus_req   = '0;
    bus_rsp   = '0;
    apb_req   = '0;
    exp_stats = '0;
    exp_drops = 0;
    m_enable  = 1'b0;
    m_base    = '0;
    m_mask    = '0;
    repeat (2) @(posedge bus);
    #2;
    reset = 1'b0;

    test_reset_disable();
    test_capture();
    test_window();
    test_stats_clear();
    test_overflow();
    test_apb_errors();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- trace/trace_fifo.sv
`timescale 1ns/1ps

`include "bus_mon_cfg.svh"

module trace_fifo
  import bus_mon_pkg::*;
#(
  parameter int DEPTH = `BUS_MON_TRACE_DEPTH
)(
  input  logic                     bus,
  input  logic                     reset,
  input  xfer_rec_t                push_rec,
  input  logic                     push,
  input  logic                     pop,
  output xfer_rec_t                head,
  output logic [$clog2(DEPTH):0]   level,
  output logic [15:0]              drops
);

  // pointer index width, extra msb tells full from empty
  localparam int PW = $clog2(DEPTH);

  //////////////////////////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////////////////////////

  xfer_rec_t     mem [DEPTH];
  logic [PW:0]   wr_ptr;
  logic [PW:0]   rd_ptr;
  logic          full;
  logic          empty;
  logic          do_push;
  logic          do_pop;

  assign level = wr_ptr - rd_ptr;
  assign full  = (level == DEPTH[PW:0]);
  assign empty = (level == '0);

  // full means the record is lost
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // oldest entry, comb read
  assign head = mem[rd_ptr[PW-1:0]];

  always_ff @(posedge bus) begin
    if (do_push) begin
      mem[wr_ptr[PW-1:0]] <= push_rec;
    end
  end

  always_ff @(posedge bus) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // overflow accounting
  //////////////////////////////////////////////////////////////////////

  // saturating, stays at all ones
  always_ff @(posedge bus) begin
    if (reset) begin
      drops <= '0;
    end else if (push && full && (drops != 16'hFFFF)) begin
      drops <= drops + 1'b1;
    end
  end

endmodule
